// File: Makefile
VERILATOR ?= verilator
TOP       ?= long_fifo_tb
FILELIST  ?= long_fifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/fifo_lane_if.sv
`timescale 1ns/1ps

// Write and read signals of one 4-bit lane.
interface fifo_lane_if import long_fifo_pkg::*; ();

    lane_data_t din;     // Write data, sampled on wr_clk.
    logic       wr_en;   // Write request. Ignored while full is high.
    logic       rd_en;   // Read request. Ignored while empty is high.
    lane_data_t dout;    // Registered read data, valid after an accepted read.
    logic       full;    // Write side flag, in the wr_clk domain.
    logic       empty;   // Read side flag, in the rd_clk domain.

    // The wide FIFO top issues requests and collects the lane results.
    modport host (
        output din,
        output wr_en,
        output rd_en,
        input  dout,
        input  full,
        input  empty
    );

    // The lane slice stores data and reports its flags.
    modport slice (
        input  din,
        input  wr_en,
        input  rd_en,
        output dout,
        output full,
        output empty
    );

endinterface

// File: hw/fifo_rst_ctrl.sv
`timescale 1ns/1ps

// Brings both lane clock domains through reset together.
// The write domain owns the sequence, the read domain echoes back its state.
module fifo_rst_ctrl import long_fifo_pkg::*; (
    input  logic wr_clk,
    input  logic rd_clk,
    input  logic rst,        // Synchronous to wr_clk.
    output logic lane_rst,   // Seen by both domains of every lane.
    output logic wr_ok,      // Write acceptance enable, wr_clk domain.
    output logic rd_ok       // Read acceptance enable, rd_clk domain.
);

    rst_state_t state;
    logic [2:0] stretch_cnt;   // Keeps lane_rst up for a minimum time after rst.
    logic       rd_rst_req;    // lane_rst as seen in the rd_clk domain.
    logic       rd_in_rst;     // Read domain acknowledge, high while it is held.
    logic       rd_in_rst_w;   // That acknowledge back in the wr_clk domain.

    // The request is a register, so it crosses without glitches.
    ptr_sync #(.payload_t(logic)) i_rst_to_rd (
        .clk (rd_clk),
        .rst (1'b0),
        .d   (lane_rst),
        .q   (rd_rst_req)
    );

    ptr_sync #(.payload_t(logic)) i_ack_to_wr (
        .clk (wr_clk),
        .rst (rst),
        .d   (rd_in_rst),
        .q   (rd_in_rst_w)
    );

    always_ff @(posedge wr_clk) begin
        if (rst) begin
            state       <= RST_HOLD;
            stretch_cnt <= '0;
            lane_rst    <= 1'b1;
            wr_ok       <= 1'b0;
        end else begin
            case (state)
                RST_HOLD: begin
                    if (stretch_cnt != '1) begin
                        stretch_cnt <= stretch_cnt + 1'b1;
                    end
                    // Release only once the read side has really been reset.
                    if ((stretch_cnt == '1) && rd_in_rst_w) begin
                        state    <= RST_RELEASE;
                        lane_rst <= 1'b0;
                    end
                end
                RST_RELEASE: begin
                    if (!rd_in_rst_w) begin   // Read side has left reset too.
                        state <= RST_RUN;
                        wr_ok <= 1'b1;
                    end
                end
                RST_RUN: begin
                    wr_ok <= 1'b1;
                end
                default: begin
                    state <= RST_HOLD;
                end
            endcase
        end
    end

    // rd_ok trails the release by one cycle, so the pointers are quiet when it rises.
    always_ff @(posedge rd_clk) begin
        if (rd_rst_req) begin
            rd_in_rst <= 1'b1;
            rd_ok     <= 1'b0;
        end else begin
            rd_in_rst <= 1'b0;
            rd_ok     <= ~rd_in_rst;
        end
    end

    // Writes may start only once the read domain itself has come out of reset.
    a_wr_ok_after_rst: assert property (@(posedge wr_clk) disable iff (rst)
        $rose(wr_ok) |-> !lane_rst && !rd_rst_req && !rd_in_rst);

endmodule

// File: hw/fifo_slice_4bit.sv
`timescale 1ns/1ps
`include "long_fifo_macros.svh"

// One 4-bit dual-clock FIFO lane.
// Pointers cross between domains in Gray code, flags are registered.
module fifo_slice_4bit import long_fifo_pkg::*; (
    input  logic       wr_clk,
    input  logic       rd_clk,
    input  logic       lane_rst,
    input  logic       wr_ok,
    input  logic       rd_ok,
    fifo_lane_if.slice lane
);

    localparam int unsigned AW    = `LONG_FIFO_AW;
    localparam int unsigned DEPTH = `LONG_FIFO_LENGTH;

    lane_data_t mem [DEPTH];   // Storage, written on wr_clk and read on rd_clk.

    fifo_ptr_t wr_bin;         // Write pointer, binary, addresses the memory.
    fifo_ptr_t wr_gray;        // Write pointer, Gray, sent to the read side.
    fifo_ptr_t wr_bin_next;
    fifo_ptr_t wr_gray_next;
    fifo_ptr_t rd_gray_w;      // Read pointer after crossing into wr_clk.
    fifo_ptr_t rd_gray_full;   // Value the write pointer has when the lane is full.
    fifo_ptr_t wr_level;       // Words held, as the write side sees it.
    fifo_ptr_t rd_bin;
    fifo_ptr_t rd_gray;
    fifo_ptr_t rd_bin_next;
    fifo_ptr_t rd_gray_next;
    fifo_ptr_t wr_gray_r;      // Write pointer after crossing into rd_clk.
    logic      full_r;
    logic      empty_r;
    logic      wr_fire;
    logic      rd_fire;

    ptr_sync #(.payload_t(fifo_ptr_t)) i_rd_to_wr (
        .clk (wr_clk),
        .rst (lane_rst),
        .d   (rd_gray),
        .q   (rd_gray_w)
    );

    ptr_sync #(.payload_t(fifo_ptr_t)) i_wr_to_rd (
        .clk (rd_clk),
        .rst (lane_rst),
        .d   (wr_gray),
        .q   (wr_gray_r)
    );

    // Flags stay asserted until the sequencer opens the lane.
    assign lane.full  = full_r | ~wr_ok;
    assign lane.empty = empty_r | ~rd_ok;

    assign wr_fire      = lane.wr_en & ~lane.full;
    assign wr_bin_next  = wr_bin + fifo_ptr_t'(wr_fire);
    assign wr_gray_next = bin2gray(wr_bin_next);
    // In Gray code a full lane differs from the read pointer in the top two bits.
    assign rd_gray_full = {~rd_gray_w[AW:AW-1], rd_gray_w[AW-2:0]};
    assign wr_level     = wr_bin - gray2bin(rd_gray_w);

    always_ff @(posedge wr_clk) begin
        if (lane_rst) begin
            wr_bin  <= '0;
            wr_gray <= '0;
            full_r  <= 1'b0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
            full_r  <= (wr_gray_next == rd_gray_full);   // Rises with the filling write.
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[AW-1:0]] <= lane.din;
        end
    end

    assign rd_fire      = lane.rd_en & ~lane.empty;
    assign rd_bin_next  = rd_bin + fifo_ptr_t'(rd_fire);
    assign rd_gray_next = bin2gray(rd_bin_next);

    // lane_rst comes from wr_clk. It only falls while rd_ok is low and the
    // pointer is already zero, so the read side sees no change at that edge.
    always_ff @(posedge rd_clk) begin
        if (lane_rst) begin
            rd_bin  <= '0;
            rd_gray <= '0;
            empty_r <= 1'b1;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
            empty_r <= (rd_gray_next == wr_gray_r);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_fire) begin
            lane.dout <= mem[rd_bin[AW-1:0]];   // Held until the next accepted read.
        end
    end

    // Across the pointer crossing, an accepted write never overruns unread data.
    a_no_overrun: assert property (@(posedge wr_clk) disable iff (lane_rst)
        wr_fire |-> (wr_level < fifo_ptr_t'(DEPTH)));

endmodule

// File: hw/long_fifo.sv
`timescale 1ns/1ps
`include "long_fifo_macros.svh"

// Wide dual-clock FIFO built from 4-bit lanes that run in lockstep.
module long_fifo import long_fifo_pkg::*; (
    input  logic                        wr_clk,
    input  logic                        rd_clk,
    input  logic                        rst,     // Synchronous to wr_clk.
    input  logic [`LONG_FIFO_DSIZE-1:0] din,
    input  logic                        wr_en,
    input  logic                        rd_en,
    output logic [`LONG_FIFO_DSIZE-1:0] dout,
    output logic                        full,
    output logic                        empty
);

    localparam int unsigned DSIZE = `LONG_FIFO_DSIZE;
    localparam int unsigned LANES = (DSIZE + 3) / 4;   // Rounded up to whole lanes.
    localparam int unsigned PAD_W = 4 * LANES;

    logic [PAD_W-1:0] din_pad;      // din with zeros above the top data bit.
    logic [PAD_W-1:0] dout_pad;     // All lane outputs side by side.
    logic [LANES-1:0] lane_full;
    logic [LANES-1:0] lane_empty;
    logic             lane_rst;
    logic             wr_ok;
    logic             rd_ok;

    fifo_rst_ctrl i_fifo_rst_ctrl (
        .wr_clk   (wr_clk),
        .rd_clk   (rd_clk),
        .rst      (rst),
        .lane_rst (lane_rst),
        .wr_ok    (wr_ok),
        .rd_ok    (rd_ok)
    );

    assign din_pad = PAD_W'(din);

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        fifo_lane_if i_lane_if ();

        // Every lane gets the same requests, so all pointers move together.
        assign i_lane_if.din   = lane_data_t'(din_pad[4*k +: 4]);
        assign i_lane_if.wr_en = wr_en;
        assign i_lane_if.rd_en = rd_en;

        assign dout_pad[4*k +: 4] = i_lane_if.dout;
        assign lane_full[k]       = i_lane_if.full;
        assign lane_empty[k]      = i_lane_if.empty;

        fifo_slice_4bit i_slice (
            .wr_clk   (wr_clk),
            .rd_clk   (rd_clk),
            .lane_rst (lane_rst),
            .wr_ok    (wr_ok),
            .rd_ok    (rd_ok),
            .lane     (i_lane_if.slice)
        );
    end

    assign dout  = dout_pad[DSIZE-1:0];   // Padding bits of the top lane are dropped.
    assign full  = lane_full[0];          // Lane 0 speaks for all lanes.
    assign empty = lane_empty[0];

    // Lanes see identical traffic, so their flags must never split.
    a_full_lockstep: assert property (@(posedge wr_clk) disable iff (lane_rst)
        (lane_full == '0) || (lane_full == '1));
    a_empty_lockstep: assert property (@(posedge rd_clk) disable iff (lane_rst)
        (lane_empty == '0) || (lane_empty == '1));

endmodule

// File: hw/long_fifo_macros.svh
`ifndef LONG_FIFO_MACROS_SVH
`define LONG_FIFO_MACROS_SVH

// Word width in bits. Lanes are 4 bits wide, so the top lane may be partly padded.
`define LONG_FIFO_DSIZE 10

// Depth in words. Must be a power of two for the Gray pointer scheme.
`define LONG_FIFO_LENGTH 64
`define LONG_FIFO_AW $clog2(`LONG_FIFO_LENGTH)

// Flops in each clock domain crossing chain.
`define LONG_FIFO_SYNC_STAGES 2

`endif

// File: hw/long_fifo_pkg.sv
`include "long_fifo_macros.svh"

package long_fifo_pkg;

    typedef logic [3:0] lane_data_t;                  // One 4-bit slice of a stored word.
    typedef logic [`LONG_FIFO_AW:0] fifo_ptr_t;       // Extra top bit tells full from empty.

    // States of the reset sequencer in the write clock domain.
    typedef enum logic [1:0] {
        RST_HOLD,                                     // Lanes held in reset.
        RST_RELEASE,                                  // Waiting for the read side to leave reset.
        RST_RUN                                       // Normal traffic.
    } rst_state_t;

    function automatic fifo_ptr_t bin2gray(input fifo_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic fifo_ptr_t gray2bin(input fifo_ptr_t gray);
        fifo_ptr_t bin;
        bin = gray;
        for (int i = $bits(fifo_ptr_t) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];              // Each bit folds in all bits above it.
        end
        return bin;
    endfunction

endpackage

// File: hw/ptr_sync.sv
`timescale 1ns/1ps
`include "long_fifo_macros.svh"

// Plain flop chain for crossing a value into the clk domain.
// Multi-bit payloads must change one bit at a time, as Gray pointers do.
module ptr_sync import long_fifo_pkg::*; #(
    parameter type payload_t = fifo_ptr_t
)(
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    localparam int unsigned STAGES = `LONG_FIFO_SYNC_STAGES;

    payload_t stage [STAGES];   // stage[0] may go metastable, the rest settle it.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[STAGES-1];   // Last stage is the only one safe to read.

endmodule

// File: long_fifo.f
+incdir+hw
hw/long_fifo_pkg.sv
hw/fifo_lane_if.sv
hw/ptr_sync.sv
hw/fifo_rst_ctrl.sv
hw/fifo_slice_4bit.sv
hw/long_fifo.sv
verif/long_fifo_checker.sv
verif/long_fifo_tb.sv

// File: verif/long_fifo_checker.sv
`timescale 1ns/1ps
`include "long_fifo_macros.svh"

// Watches the FIFO ports, keeps a model of the accepted words and compares every read.
module long_fifo_checker (
    input logic                        wr_clk,
    input logic                        rd_clk,
    input logic                        rst,
    input logic [`LONG_FIFO_DSIZE-1:0] din,
    input logic                        wr_en,
    input logic                        rd_en,
    input logic [`LONG_FIFO_DSIZE-1:0] dout,
    input logic                        full,
    input logic                        empty
);

    localparam int DSIZE  = `LONG_FIFO_DSIZE;
    localparam int LENGTH = `LONG_FIFO_LENGTH;

    typedef logic [DSIZE-1:0] word_t;

    word_t model_q [$];        // Every accepted write, in order. Only the write side pushes.
    int    rd_count = 0;       // Index of the next word the read side expects.
    word_t expected;
    word_t held;               // Last word seen on dout after an accepted read.
    logic  compare_due = 1'b0;
    logic  held_valid = 1'b0;
    string test_name = "reset";
    int    wr_checks = 0;
    int    wr_errors = 0;
    int    rd_checks = 0;
    int    rd_errors = 0;
    int    flow_checks = 0;
    int    flow_errors = 0;
    int    test_count = 0;
    int    checks_at_start = 0;
    int    errors_at_start = 0;

    // A stored word comes back as the low DSIZE bits of what was written.
    function automatic word_t expected_word(input logic [31:0] raw);
        logic [31:0] mask;
        mask = (32'd1 << DSIZE) - 32'd1;
        return word_t'(raw & mask);
    endfunction

    function automatic int error_total();
        return wr_errors + rd_errors + flow_errors;
    endfunction

    function automatic int check_total();
        return wr_checks + rd_checks + flow_checks;
    endfunction

    function automatic int pending_words();
        return model_q.size() - rd_count;   // Written but not yet read.
    endfunction

    // Write side. A write lands when wr_en is high and full is low at the edge.
    always @(posedge wr_clk) begin
        if (!rst && !full && (pending_words() >= LENGTH)) begin
            wr_errors++;
            $display("%s: full is low with %0d unread words", test_name, pending_words());
        end
        if (wr_en && !full) begin
            wr_checks++;
            if (pending_words() >= LENGTH) begin
                wr_errors++;
                $display("%s: write accepted into a full FIFO", test_name);
            end
            model_q.push_back(expected_word(32'(din)));
        end
    end

    // Read side. dout is checked one edge after the read that fetched it.
    always @(posedge rd_clk) begin
        if (compare_due) begin
            rd_checks++;
            if (dout !== expected) begin
                rd_errors++;
                $display("mismatch %s: expected %h, actual %h", test_name, expected, dout);
            end
            held       = dout;
            held_valid = 1'b1;
        end else if (held_valid && (dout !== held)) begin
            rd_errors++;   // Data must hold between accepted reads.
            $display("%s: dout changed without an accepted read", test_name);
        end
        compare_due = 1'b0;
        if (rst && !empty) begin
            rd_errors++;
            $display("%s: empty is low during reset", test_name);
        end
        if (rd_en && !empty) begin
            if (rd_count >= model_q.size()) begin
                rd_errors++;
                $display("%s: read accepted with no word written", test_name);
            end else begin
                expected    = model_q[rd_count];
                rd_count++;
                compare_due = 1'b1;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        flow_checks++;
        if (act !== exp) begin
            flow_errors++;
            $display("mismatch %s (%s): expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        flow_checks++;
        flow_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = check_total();
        errors_at_start = error_total();
    endtask

    task automatic finish_test();
        test_count++;
        $display("test %s: %0d checks, %0d errors", test_name,
                 check_total() - checks_at_start, error_total() - errors_at_start);
    endtask

    task automatic summary();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_total(), error_total());
    endtask

endmodule

// File: verif/long_fifo_tb.sv
`timescale 1ns/1ps
`include "long_fifo_macros.svh"

module long_fifo_tb;

    localparam int          DSIZE          = `LONG_FIFO_DSIZE;
    localparam int          LENGTH         = `LONG_FIFO_LENGTH;
    localparam int          RANDOM_WRITES  = 500;
    localparam int          OVERFLOW_TRIES = 8;
    localparam int          TOTAL_WORDS    = 1 + LENGTH + OVERFLOW_TRIES + 3 + RANDOM_WRITES;
    localparam int          TIMEOUT_NS     = TOTAL_WORDS * 20 * 100;   // 20 write periods a word.
    localparam logic [31:0] SEED           = 32'hfc10_ff18;

    logic             wr_clk;
    logic             rd_clk;
    logic             rst;
    logic [DSIZE-1:0] din;
    logic [DSIZE-1:0] dout;
    logic             wr_en;
    logic             rd_en;
    logic             full;
    logic             empty;
    logic [31:0]      wr_lfsr;   // Random source of the write side.
    logic [31:0]      rd_lfsr;   // The read side runs its own copy, so edge order is irrelevant.

    long_fifo i_long_fifo (.*);
    long_fifo_checker i_checker (.*);

    initial begin
        wr_clk = 1'b0;
        forever #50 wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #35 rd_clk = ~rd_clk;   // Unrelated to wr_clk, edges drift against it.
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int n, inout logic [31:0] state, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};   // One step for every bit taken.
        end
    endtask

    task automatic write_word(input logic [DSIZE-1:0] w);
        @(posedge wr_clk);
        din   <= w;
        wr_en <= 1'b1;
        do begin
            @(posedge wr_clk);
        end while (full);                     // Accepted on the first edge with full low.
        wr_en <= 1'b0;
    endtask

    task automatic read_word();
        @(posedge rd_clk);
        rd_en <= 1'b1;
        do begin
            @(posedge rd_clk);
        end while (empty);
        rd_en <= 1'b0;
    endtask

    // The last read is compared one edge later, so give the checker time before the report.
    task automatic close_test();
        repeat (2) @(posedge rd_clk);
        #1;
        i_checker.finish_test();
    endtask

    initial begin
        int          waited;
        int          count;
        int          accepted;
        int          reads_done;
        logic [31:0] wbits;
        logic [31:0] rbits;
        rst     = 1'b1;
        din     = '0;
        wr_en   = 1'b0;
        rd_en   = 1'b1;   // Reads are requested all through reset, and none may land.
        wr_lfsr = SEED;
        rd_lfsr = SEED;

        i_checker.start_test("reset");
        repeat (4) @(posedge wr_clk);
        rst    <= 1'b0;
        waited = 0;
        while (full && (waited < 50)) begin   // Sequencer needs well under 50 cycles.
            @(posedge wr_clk);
            waited++;
        end
        if (full) begin
            i_checker.report_failure("full stayed high after reset");
        end
        i_checker.check_value("empty after reset", 32'd1, 32'(empty));
        @(posedge rd_clk);
        rd_en <= 1'b0;
        i_checker.finish_test();

        i_checker.start_test("single");
        take_bits(DSIZE, wr_lfsr, wbits);
        write_word(wbits[DSIZE-1:0]);
        read_word();
        @(posedge rd_clk);
        i_checker.check_value("empty after read", 32'd1, 32'(empty));
        close_test();

        i_checker.start_test("fill");
        repeat (10) @(posedge wr_clk);        // Read pointer settles on the write side.
        count = 0;
        @(posedge wr_clk);
        take_bits(DSIZE, wr_lfsr, wbits);
        din   <= wbits[DSIZE-1:0];
        wr_en <= 1'b1;
        do begin
            @(posedge wr_clk);
            if (!full) begin
                count++;
                take_bits(DSIZE, wr_lfsr, wbits);
                din <= wbits[DSIZE-1:0];
            end
        end while (!full && (count <= LENGTH));
        i_checker.check_value("writes until full", 32'(LENGTH), 32'(count));
        i_checker.finish_test();

        i_checker.start_test("overflow");
        repeat (OVERFLOW_TRIES) begin         // wr_en stays high against a full FIFO.
            @(posedge wr_clk);
            if (!full) begin
                i_checker.report_failure("full fell with no reads");
            end
            take_bits(DSIZE, wr_lfsr, wbits);
            din <= wbits[DSIZE-1:0];
        end
        wr_en <= 1'b0;
        repeat (LENGTH) read_word();
        @(posedge rd_clk);
        i_checker.check_value("empty after drain", 32'd1, 32'(empty));
        close_test();
        i_checker.check_value("words left after drain", 32'd0, 32'(i_checker.pending_words()));

        i_checker.start_test("underflow");
        @(posedge rd_clk);
        rd_en <= 1'b1;
        repeat (6) @(posedge rd_clk);
        rd_en <= 1'b0;
        repeat (3) begin
            take_bits(DSIZE, wr_lfsr, wbits);
            write_word(wbits[DSIZE-1:0]);
        end
        repeat (3) read_word();
        close_test();

        i_checker.start_test("random");
        accepted   = 0;
        reads_done = 0;
        fork
            while (accepted < RANDOM_WRITES) begin
                @(posedge wr_clk);
                if (wr_en && !full) begin
                    accepted++;
                end
                if (accepted < RANDOM_WRITES) begin
                    take_bits(1, wr_lfsr, wbits);
                    wr_en <= wbits[0];
                    take_bits(DSIZE, wr_lfsr, wbits);
                    din <= wbits[DSIZE-1:0];
                end else begin
                    wr_en <= 1'b0;
                end
            end
            while (reads_done < RANDOM_WRITES) begin
                @(posedge rd_clk);
                if (rd_en && !empty) begin
                    reads_done++;
                end
                if (reads_done < RANDOM_WRITES) begin
                    take_bits(2, rd_lfsr, rbits);
                    rd_en <= &rbits[1:0];     // Reads at a quarter rate, so full is reached.
                end else begin
                    rd_en <= 1'b0;
                end
            end
        join
        close_test();
        i_checker.check_value("words left after traffic", 32'd0, 32'(i_checker.pending_words()));

        i_checker.summary();
        if (i_checker.error_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests still running at %0t", $time);
        $display("Test failed");
        $finish;
    end

endmodule
